/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = cpuTb
FLIST     = flist.f
OBJDIR    = obj_dir
PASS_MSG  = all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

# The simulation passes only when the pass message appears on a line of its own.
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
  input  logic [cpuPkg::dataWidth-1:0] operandA,
  input  logic [cpuPkg::dataWidth-1:0] operandB,
  input  cpuPkg::aluOp                 op,
  output logic [cpuPkg::dataWidth-1:0] result,
  output logic                         zero
);

  logic lessThan;

  // Signed compare for slt.
  assign lessThan = $signed(operandA) < $signed(operandB);

  always_comb begin
    unique case (op)
      cpuPkg::aluAdd: begin
        result = operandA + operandB;
      end
      cpuPkg::aluSub: begin
        result = operandA - operandB;
      end
      cpuPkg::aluSlt: begin
        result = {{(cpuPkg::dataWidth-1){1'b0}}, lessThan};
      end
      cpuPkg::aluXor: begin
        result = operandA ^ operandB;
      end
    endcase
  end

  assign zero = (result == '0);

endmodule

`default_nettype wire

/* controlUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module controlUnit (
  input  cpuPkg::instrWord   instr,
  output cpuPkg::ctrlSignals ctrl
);

  always_comb begin
    ctrl = '0;
    ctrl.aluControl = cpuPkg::aluAdd;
    case (instr.rFields.op)
      cpuPkg::opLw: begin
        ctrl.regWrite = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.aluSrc   = 1'b1;
      end
      cpuPkg::opSw: begin
        ctrl.memWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;
      end
      cpuPkg::opJ: begin
        ctrl.jump = 1'b1;
      end
      cpuPkg::opJal: begin
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      cpuPkg::opBne: begin
        // The ALU subtracts so that its zero flag reports equality.
        ctrl.branch     = 1'b1;
        ctrl.aluControl = cpuPkg::aluSub;
      end
      cpuPkg::opXori: begin
        ctrl.regWrite   = 1'b1;
        ctrl.aluSrc     = 1'b1;
        ctrl.zeroExtend = 1'b1;
        ctrl.aluControl = cpuPkg::aluXor;
      end
      cpuPkg::opRtype: begin
        case (instr.rFields.funct)
          cpuPkg::functAdd: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = 1'b1;
          end
          cpuPkg::functSub: begin
            ctrl.regWrite   = 1'b1;
            ctrl.regDst     = 1'b1;
            ctrl.aluControl = cpuPkg::aluSub;
          end
          cpuPkg::functSlt: begin
            ctrl.regWrite   = 1'b1;
            ctrl.regDst     = 1'b1;
            ctrl.aluControl = cpuPkg::aluSlt;
          end
          cpuPkg::functJr: begin
            ctrl.jumpReg = 1'b1;
          end
          default: begin
            ctrl.illegal = 1'b1;
          end
        endcase
      end
      default: begin
        ctrl.illegal = 1'b1;
      end
    endcase
  end

  // No instruction in the set both stores and writes a register.
  assert property (@(instr) !(ctrl.memWrite && ctrl.regWrite))
    else $error("controlUnit: memWrite and regWrite both set");

endmodule

`default_nettype wire

/* cpuPkg.sv */
`default_nettype none

package cpuPkg;

  localparam int dataWidth    = 32;
  localparam int regAddrWidth = 5;
  localparam int regCount     = 2 ** regAddrWidth;
  localparam int imemDepth    = 64;
  localparam int dmemDepth    = 64;

  // Word index widths of the two memories.
  localparam int imemAddrWidth = $clog2(imemDepth);
  localparam int dmemAddrWidth = $clog2(dmemDepth);

  localparam logic [5:0] opRtype = 6'h00;
  localparam logic [5:0] opJ     = 6'h02;
  localparam logic [5:0] opJal   = 6'h03;
  localparam logic [5:0] opBne   = 6'h05;
  localparam logic [5:0] opXori  = 6'h0e;
  localparam logic [5:0] opLw    = 6'h23;
  localparam logic [5:0] opSw    = 6'h2b;

  localparam logic [5:0] functJr  = 6'h08;
  localparam logic [5:0] functAdd = 6'h20;
  localparam logic [5:0] functSub = 6'h22;
  localparam logic [5:0] functSlt = 6'h2a;

  // Return address register written by jal.
  localparam logic [regAddrWidth-1:0] linkReg = 5'd31;

  typedef enum logic [1:0] {
    aluAdd,
    aluSub,
    aluSlt,
    aluXor
  } aluOp;

  typedef struct packed {
    logic [5:0]              op;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [regAddrWidth-1:0] rd;
    logic [4:0]              shamt;
    logic [5:0]              funct;
  } rFormat;

  typedef struct packed {
    logic [5:0]              op;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [15:0]             imm;
  } iFormat;

  typedef struct packed {
    logic [5:0]  op;
    logic [25:0] target;
  } jFormat;

  // The same fetched word, read as whichever format the opcode selects.
  typedef union packed {
    rFormat rFields;
    iFormat iFields;
    jFormat jFields;
  } instrWord;

  typedef struct packed {
    logic regWrite;
    logic memToReg;
    logic memWrite;
    logic branch;
    logic aluSrc;
    logic regDst;
    aluOp aluControl;
    logic jump;
    logic jumpReg;
    logic link;
    logic zeroExtend;
    logic illegal;
  } ctrlSignals;

  typedef struct packed {
    logic                    valid;
    logic [dataWidth-1:0]    pc;
    logic                    regWrite;
    logic [regAddrWidth-1:0] destReg;
    logic [dataWidth-1:0]    writeData;
    logic                    memWrite;
    logic [dataWidth-1:0]    memAddr;
    logic [dataWidth-1:0]    storeData;
  } retireInfo;

endpackage

`default_nettype wire

/* tbProgram.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

function automatic logic [31:0] encR(input logic [5:0] funct, input logic [4:0] rd,
                                     input logic [4:0] rs, input logic [4:0] rt);
  return {cpuPkg::opRtype, rs, rt, rd, 5'd0, funct};
endfunction

function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rt,
                                     input logic [4:0] rs, input logic [15:0] imm);
  return {op, rs, rt, imm};
endfunction

function automatic logic [31:0] encJ(input logic [5:0] op, input logic [25:0] target);
  return {op, target};
endfunction

localparam int progLength  = 21;
localparam int retireCount = 20;

// Program slots whose xori immediate the testbench draws from $urandom.
localparam int randomSlots [2] = '{0, 1};

// Byte address of the word that the sw and lw pair share.
localparam logic [15:0] memSlot = 16'd8;

localparam logic [31:0] progTemplate [progLength] = '{
  encI(cpuPkg::opXori, 5'd1, 5'd0, 16'h0000),
  encI(cpuPkg::opXori, 5'd2, 5'd0, 16'h0000),
  encI(cpuPkg::opXori, 5'd10, 5'd0, 16'h0001),
  encR(cpuPkg::functAdd, 5'd3, 5'd1, 5'd2),
  encR(cpuPkg::functSub, 5'd4, 5'd1, 5'd2),
  encR(cpuPkg::functSub, 5'd6, 5'd0, 5'd1),
  encR(cpuPkg::functSlt, 5'd7, 5'd6, 5'd2),
  encR(cpuPkg::functSlt, 5'd8, 5'd2, 5'd6),
  encI(cpuPkg::opSw, 5'd3, 5'd0, memSlot),
  encI(cpuPkg::opLw, 5'd9, 5'd0, memSlot),
  // Equal operands, so this branch falls through.
  encI(cpuPkg::opBne, 5'd10, 5'd10, 16'd2),
  // Taken, skipping word 12.
  encI(cpuPkg::opBne, 5'd0, 5'd10, 16'd1),
  encI(cpuPkg::opXori, 5'd12, 5'd0, 16'hdead),
  encI(cpuPkg::opXori, 5'd0, 5'd10, 16'h0055),
  encR(cpuPkg::functAdd, 5'd11, 5'd0, 5'd10),
  encJ(cpuPkg::opJal, 26'd18),
  encJ(cpuPkg::opJ, 26'd20),
  encI(cpuPkg::opXori, 5'd13, 5'd0, 16'h0bad),
  encI(cpuPkg::opXori, 5'd14, 5'd9, 16'h00ff),
  encR(cpuPkg::functJr, 5'd0, 5'd31, 5'd0),
  // Final self loop keeps retiring until the run ends.
  encJ(cpuPkg::opJ, 26'd20)
};

// Program with the random immediates filled in, as loaded into the DUT.
logic [31:0] progTable [progLength];

// Expected retire records, in retire order.
cpuPkg::retireInfo expectTable [retireCount];

`endif

/* cpuTb.sv */
`timescale 1ns/1ns
`default_nettype none

module cpuTb;

  `include "tbProgram.svh"

  localparam int clkPeriod    = 8;
  localparam int resetCycles  = 16;
  localparam int retireLimit  = 8;
  localparam int marginCycles = 20;
  localparam int randomSeed   = 18812;
  localparam int runCycles    = progLength + resetCycles + retireLimit + retireCount
                                + marginCycles;

  typedef logic [cpuPkg::imemAddrWidth-1:0] imemIndex;

  logic                         clk;
  logic                         reset;
  logic                         imemLoad;
  imemIndex                     imemAddr;
  logic [cpuPkg::dataWidth-1:0] imemData;
  cpuPkg::retireInfo            retire;
  int                           errorCount;
  int                           checkCount;
  logic [15:0]                  immA;
  logic [15:0]                  immB;
  logic                         retired;

  cpuTop UUT (
    .clk(clk), .reset(reset), .imemLoad(imemLoad), .imemAddr(imemAddr),
    .imemData(imemData), .retire(retire)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(runCycles * clkPeriod);
    $display("Run stopped by the watchdog after %0d cycles.", runCycles);
    $display("tests failed");
    $finish;
  end

  function automatic cpuPkg::retireInfo plainRecord(input logic [31:0] pc);
    cpuPkg::retireInfo rec;
    rec = '0;
    rec.valid = 1'b1;
    rec.pc = pc;
    return rec;
  endfunction

  function automatic cpuPkg::retireInfo regRecord(input logic [31:0] pc, input logic [4:0] dest,
                                                  input logic [31:0] data);
    cpuPkg::retireInfo rec;
    rec = plainRecord(pc);
    rec.regWrite = 1'b1;
    rec.destReg = dest;
    rec.writeData = data;
    return rec;
  endfunction

  function automatic cpuPkg::retireInfo storeRecord(input logic [31:0] pc,
                                                    input logic [31:0] addr,
                                                    input logic [31:0] data);
    cpuPkg::retireInfo rec;
    rec = plainRecord(pc);
    rec.memWrite = 1'b1;
    rec.memAddr = addr;
    rec.storeData = data;
    return rec;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  // Destination and data fields only matter when the record says they are written.
  task automatic compareRetire(input cpuPkg::retireInfo expected);
    checkValue("retire.valid", 32'(retire.valid), 32'(expected.valid));
    checkValue("retire.pc", retire.pc, expected.pc);
    checkValue("retire.regWrite", 32'(retire.regWrite), 32'(expected.regWrite));
    checkValue("retire.memWrite", 32'(retire.memWrite), 32'(expected.memWrite));
    if (expected.regWrite) begin
      checkValue("retire.destReg", 32'(retire.destReg), 32'(expected.destReg));
      checkValue("retire.writeData", retire.writeData, expected.writeData);
    end
    if (expected.memWrite) begin
      checkValue("retire.memAddr", retire.memAddr, expected.memAddr);
      checkValue("retire.storeData", retire.storeData, expected.storeData);
    end
  endtask

  task automatic buildTables();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sum;
    logic [31:0] negA;
    logic [31:0] memAddr;
    logic [15:0] branchImm;
    logic [31:0] takenPc;
    logic [31:0] jalPc;
    logic [31:0] linkPc;
    logic [31:0] loopPc;
    // A nonzero first immediate makes its negation a negative slt operand.
    immA = 16'($urandom_range(65535, 1));
    // With its top bit set, the second immediate shows whether xori zero-extends.
    immB = 16'($urandom) | 16'h8000;
    foreach (progTable[i]) begin
      progTable[i] = progTemplate[i];
    end
    progTable[randomSlots[0]] = {progTemplate[randomSlots[0]][31:16], immA};
    progTable[randomSlots[1]] = {progTemplate[randomSlots[1]][31:16], immB};

    a = {16'b0, immA};
    b = {16'b0, immB};
    sum = a + b;
    negA = 32'd0 - a;
    memAddr = {{16{memSlot[15]}}, memSlot};
    branchImm = progTemplate[11][15:0];
    takenPc = 32'd44 + 32'd4 + {{14{branchImm[15]}}, branchImm, 2'b00};
    jalPc = {4'b0, progTemplate[15][25:0], 2'b00};
    linkPc = 32'd60 + 32'd4;
    loopPc = {4'b0, progTemplate[16][25:0], 2'b00};

    expectTable[0]  = regRecord(32'd0, 5'd1, a);
    expectTable[1]  = regRecord(32'd4, 5'd2, b);
    expectTable[2]  = regRecord(32'd8, 5'd10, 32'd1);
    expectTable[3]  = regRecord(32'd12, 5'd3, sum);
    expectTable[4]  = regRecord(32'd16, 5'd4, a - b);
    expectTable[5]  = regRecord(32'd20, 5'd6, negA);
    // The negated register is below zero and the other operand is not.
    expectTable[6]  = regRecord(32'd24, 5'd7, 32'd1);
    expectTable[7]  = regRecord(32'd28, 5'd8, 32'd0);
    expectTable[8]  = storeRecord(32'd32, memAddr, sum);
    expectTable[9]  = regRecord(32'd36, 5'd9, sum);
    expectTable[10] = plainRecord(32'd40);
    expectTable[11] = plainRecord(32'd44);
    // The write to register zero still shows on the retire port.
    expectTable[12] = regRecord(takenPc, 5'd0, 32'd1 ^ {16'b0, progTemplate[13][15:0]});
    expectTable[13] = regRecord(takenPc + 32'd4, 5'd11, 32'd1);
    expectTable[14] = regRecord(32'd60, 5'd31, linkPc);
    expectTable[15] = regRecord(jalPc, 5'd14, sum ^ {16'b0, progTemplate[18][15:0]});
    expectTable[16] = plainRecord(jalPc + 32'd4);
    expectTable[17] = plainRecord(linkPc);
    expectTable[18] = plainRecord(loopPc);
    expectTable[19] = plainRecord(loopPc);
  endtask

  task automatic loadProgram();
    for (int i = 0; i < progLength; i++) begin
      @(negedge clk);
      checkValue("retire.valid", 32'(retire.valid), 32'd0);
      imemLoad = 1'b1;
      imemAddr = imemIndex'(i);
      imemData = progTable[i];
    end
  endtask

  task automatic holdReset();
    for (int c = 0; c < resetCycles; c++) begin
      @(negedge clk);
      checkValue("retire.valid", 32'(retire.valid), 32'd0);
      imemLoad = 1'b0;
    end
  endtask

  task automatic waitForRetire(output logic found);
    int cycles;
    found = 1'b0;
    cycles = 0;
    while (!found && cycles < retireLimit) begin
      @(negedge clk);
      cycles++;
      found = retire.valid;
    end
  endtask

  task automatic printSummary();
    $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  initial begin
    errorCount = 0;
    checkCount = 0;
    reset = 1'b1;
    imemLoad = 1'b0;
    imemAddr = '0;
    imemData = '0;
    immA = '0;
    immB = '0;
    retired = 1'b0;
    void'($urandom(randomSeed));
    buildTables();
    loadProgram();
    holdReset();
    @(negedge clk);
    reset = 1'b0;
    // The cycle right after reset falls still retires nothing.
    #(clkPeriod / 4);
    checkValue("retire.valid", 32'(retire.valid), 32'd0);
    waitForRetire(retired);
    if (retired) begin
      for (int i = 0; i < retireCount; i++) begin
        if (i > 0) begin
          @(negedge clk);
        end
        compareRetire(expectTable[i]);
      end
    end else begin
      $display("No instruction retired within %0d cycles after reset fell.", retireLimit);
      errorCount++;
    end
    printSummary();
  end

endmodule

`default_nettype wire

/* cpuTop.sv */
`timescale 1ns/1ns
`default_nettype none

module cpuTop (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             imemLoad,
  input  logic [cpuPkg::imemAddrWidth-1:0] imemAddr,
  input  logic [cpuPkg::dataWidth-1:0]     imemData,
  output cpuPkg::retireInfo                retire
);

  cpuPkg::instrWord                instr;
  cpuPkg::ctrlSignals              ctrl;
  logic [cpuPkg::dataWidth-1:0]    pc;
  logic [cpuPkg::dataWidth-1:0]    pcPlus4;
  logic [cpuPkg::dataWidth-1:0]    rsValue;
  logic [cpuPkg::dataWidth-1:0]    rtValue;
  logic [cpuPkg::dataWidth-1:0]    immExtended;
  logic [cpuPkg::dataWidth-1:0]    aluOperandB;
  logic [cpuPkg::dataWidth-1:0]    aluResult;
  logic                            aluZero;
  logic [cpuPkg::dataWidth-1:0]    loadData;
  logic [cpuPkg::dataWidth-1:0]    writeBack;
  logic [cpuPkg::regAddrWidth-1:0] writeReg;
  logic                            running;

  fetchUnit fetch (
    .clk(clk), .reset(reset), .imemLoad(imemLoad), .imemAddr(imemAddr),
    .imemData(imemData), .ctrl(ctrl), .aluZero(aluZero), .rsValue(rsValue),
    .pc(pc), .instr(instr)
  );

  controlUnit decode (.instr(instr), .ctrl(ctrl));

  registerFile regFile (
    .clk(clk), .reset(reset),
    .readAddrA(instr.rFields.rs), .readAddrB(instr.rFields.rt),
    .writeEnable(ctrl.regWrite && running), .writeAddr(writeReg),
    .writeData(writeBack), .readDataA(rsValue), .readDataB(rtValue)
  );

  alu execute (
    .operandA(rsValue), .operandB(aluOperandB), .op(ctrl.aluControl),
    .result(aluResult), .zero(aluZero)
  );

  dataMemory dmem (
    .clk(clk), .writeEnable(ctrl.memWrite && running), .address(aluResult),
    .writeData(rtValue), .readData(loadData)
  );

  // Low for the first cycle after reset, matching the held pc in fetch.
  always_ff @(posedge clk) begin
    if (reset) begin
      running <= 1'b0;
    end else begin
      running <= 1'b1;
    end
  end

  assign pcPlus4     = pc + 32'd4;
  assign immExtended = ctrl.zeroExtend ? {16'b0, instr.iFields.imm}
                                       : {{16{instr.iFields.imm[15]}}, instr.iFields.imm};
  assign aluOperandB = ctrl.aluSrc ? immExtended : rtValue;

  assign writeBack = ctrl.memToReg ? loadData : (ctrl.link ? pcPlus4 : aluResult);
  assign writeReg  = ctrl.link ? cpuPkg::linkReg
                   : (ctrl.regDst ? instr.rFields.rd : instr.rFields.rt);

  always_comb begin
    retire.valid     = running;
    retire.pc        = pc;
    retire.regWrite  = ctrl.regWrite;
    retire.destReg   = writeReg;
    retire.writeData = writeBack;
    retire.memWrite  = ctrl.memWrite;
    retire.memAddr   = aluResult;
    retire.storeData = rtValue;
  end

  // Every fetched and retired word must decode to a supported instruction.
  assert property (@(posedge clk) disable iff (reset) running |-> !ctrl.illegal)
    else $error("cpuTop: illegal instruction %h at pc %h", instr, pc);

endmodule

`default_nettype wire

/* dataMemory.sv */
`timescale 1ns/1ns
`default_nettype none

module dataMemory (
  input  logic                         clk,
  input  logic                         writeEnable,
  input  logic [cpuPkg::dataWidth-1:0] address,
  input  logic [cpuPkg::dataWidth-1:0] writeData,
  output logic [cpuPkg::dataWidth-1:0] readData
);

  logic [cpuPkg::dataWidth-1:0]     mem [cpuPkg::dmemDepth];
  logic [cpuPkg::dmemAddrWidth-1:0] wordIndex;

  // Byte address to word index. Upper bits alias.
  assign wordIndex = address[cpuPkg::dmemAddrWidth+1:2];
  assign readData  = mem[wordIndex];

  always_ff @(posedge clk) begin
    if (writeEnable) begin
      mem[wordIndex] <= writeData;
    end
  end

  assert property (@(posedge clk) writeEnable |-> address[1:0] == 2'b00)
    else $error("dataMemory: unaligned store to %h", address);

endmodule

`default_nettype wire

/* fetchUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module fetchUnit (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             imemLoad,
  input  logic [cpuPkg::imemAddrWidth-1:0] imemAddr,
  input  logic [cpuPkg::dataWidth-1:0]     imemData,
  input  cpuPkg::ctrlSignals               ctrl,
  input  logic                             aluZero,
  input  logic [cpuPkg::dataWidth-1:0]     rsValue,
  output logic [cpuPkg::dataWidth-1:0]     pc,
  output cpuPkg::instrWord                 instr
);

  logic [cpuPkg::dataWidth-1:0] imem [cpuPkg::imemDepth];
  logic [cpuPkg::dataWidth-1:0] pcPlus4;
  logic [cpuPkg::dataWidth-1:0] branchOffset;
  logic [cpuPkg::dataWidth-1:0] branchTarget;
  logic [cpuPkg::dataWidth-1:0] jumpTarget;
  logic [cpuPkg::dataWidth-1:0] nextPc;
  logic                         started;

  // Only the low word index bits select the entry, so fetch wraps.
  assign instr = imem[pc[cpuPkg::imemAddrWidth+1:2]];

  assign pcPlus4      = pc + 32'd4;
  assign branchOffset = {{(cpuPkg::dataWidth-18){instr.iFields.imm[15]}},
                         instr.iFields.imm, 2'b00};
  assign branchTarget = pcPlus4 + branchOffset;
  assign jumpTarget   = {pcPlus4[31:28], instr.jFields.target, 2'b00};

  always_comb begin
    if (ctrl.jumpReg) begin
      nextPc = rsValue;
    end else if (ctrl.jump) begin
      nextPc = jumpTarget;
    end else if (ctrl.branch && !aluZero) begin
      nextPc = branchTarget;
    end else begin
      nextPc = pcPlus4;
    end
  end

  // The pc holds at zero for one cycle after reset while nothing retires.
  always_ff @(posedge clk) begin
    if (reset) begin
      pc      <= '0;
      started <= 1'b0;
    end else begin
      started <= 1'b1;
      if (started) begin
        pc <= nextPc;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset && imemLoad) begin
      imem[imemAddr] <= imemData;
    end
  end

  // A jr to a misaligned register value would break this.
  assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else $error("fetchUnit: pc not word aligned");

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
cpuPkg.sv
controlUnit.sv
fetchUnit.sv
registerFile.sv
alu.sv
dataMemory.sv
cpuTop.sv
cpuTb.sv

/* registerFile.sv */
`timescale 1ns/1ns
`default_nettype none

module registerFile (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [cpuPkg::regAddrWidth-1:0] readAddrA,
  input  logic [cpuPkg::regAddrWidth-1:0] readAddrB,
  input  logic                            writeEnable,
  input  logic [cpuPkg::regAddrWidth-1:0] writeAddr,
  input  logic [cpuPkg::dataWidth-1:0]    writeData,
  output logic [cpuPkg::dataWidth-1:0]    readDataA,
  output logic [cpuPkg::dataWidth-1:0]    readDataB
);

  logic [cpuPkg::dataWidth-1:0] regs [cpuPkg::regCount];

  assign readDataA = regs[readAddrA];
  assign readDataB = regs[readAddrB];

  // Register zero is never written, so it keeps the value reset gave it.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < cpuPkg::regCount; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable && writeAddr != '0) begin
      regs[writeAddr] <= writeData;
    end
  end

endmodule

`default_nettype wire
